// ==== include/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// tag width, entry 0 reserved for "operand ready"
`define LSU_TAG_W 4

// buffer depth, 2**LSU_TAG_W
`define LSU_ENTRIES 16

// data and address width
`define LSU_DATA_W 32

// byte lanes per word
`define LSU_SEL_W (`LSU_DATA_W / 8)

// data memory depth in words
`define LSU_MEM_WORDS 256

`endif

// ==== design/lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        MAU_IDLE,
        MAU_BUS,
        MAU_DONE
    } mau_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT_LSU,
        ARB_GRANT_HOST
    } arb_state_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`LSU_TAG_W-1:0]  tag;
        logic [`LSU_DATA_W-1:0] imm;
        logic [`LSU_TAG_W-1:0]  rs1_tag;
        logic [`LSU_DATA_W-1:0] rs1_val;
        logic [`LSU_TAG_W-1:0]  rs2_tag;
        logic [`LSU_DATA_W-1:0] rs2_val;
    } dispatch_t;

    typedef struct packed {
        logic                   valid;
        logic [`LSU_TAG_W-1:0]  tag;
        logic [`LSU_DATA_W-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_TAG_W-1:0] tag;
    } commit_t;

    typedef struct packed {
        logic [`LSU_TAG_W-1:0]  tag;
        mem_op_e                op;
        logic [`LSU_DATA_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LSU_DATA_W-1:0] adr;
        logic [`LSU_DATA_W-1:0] dat;
        logic [`LSU_SEL_W-1:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic                   ack;
        logic [`LSU_DATA_W-1:0] dat;
    } wb_s2m_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_TAG_W-1:0] tag;
    } store_done_t;

    function automatic logic is_store_op(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

// ==== design/load_store_buffer.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module load_store_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dispatch_valid,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::cdb_t      ex_cdb,
    input  lsu_pkg::cdb_t      load_cdb,
    input  lsu_pkg::commit_t   commit,
    output logic               req_valid,
    output lsu_pkg::mem_req_t  req,
    input  logic               req_ready,
    output logic               full
);
    import lsu_pkg::*;

    localparam int N  = `LSU_ENTRIES;
    localparam int TW = `LSU_TAG_W;
    localparam int DW = `LSU_DATA_W;

    logic [N-1:0]  occupied;
    logic [N-1:0]  is_store;
    logic [N-1:0]  issued;
    logic [N-1:0]  committed;
    logic [N-1:0]  rs1_ok;
    logic [N-1:0]  rs2_ok;
    mem_op_e       op_q     [N];
    logic [DW-1:0] imm_q    [N];
    logic [TW-1:0] rs1_tag  [N];
    logic [TW-1:0] rs2_tag  [N];
    logic [DW-1:0] rs1_val  [N];
    logic [DW-1:0] rs2_val  [N];

    logic [N-1:0]  rs1_wake;
    logic [N-1:0]  rs2_wake;
    logic [DW-1:0] rs1_wdata [N];
    logic [DW-1:0] rs2_wdata [N];
    logic [N-1:0]  eligible_st;
    logic [N-1:0]  eligible_ld;
    logic          pick_found;
    logic [TW-1:0] pick;
    logic          issue_now;
    logic          req_fire;
    logic          dp_rs1_ok;
    logic          dp_rs2_ok;
    logic [DW-1:0] dp_rs1_val;
    logic [DW-1:0] dp_rs2_val;

    function automatic logic tag_hit(logic [TW-1:0] t, cdb_t c);
        return c.valid && (c.tag == t);
    endfunction

    // tag 0 means the value came with the dispatch
    function automatic logic resolve_ok(logic [TW-1:0] t);
        return (t == '0) || tag_hit(t, ex_cdb) || tag_hit(t, load_cdb);
    endfunction

    function automatic logic [DW-1:0] resolve_val(logic [TW-1:0] t, logic [DW-1:0] v);
        if (t != '0 && tag_hit(t, ex_cdb)) begin
            return ex_cdb.data;
        end
        if (t != '0 && tag_hit(t, load_cdb)) begin
            return load_cdb.data;
        end
        return v;
    endfunction

    assign dp_rs1_ok  = resolve_ok(dispatch.rs1_tag);
    assign dp_rs2_ok  = resolve_ok(dispatch.rs2_tag);
    assign dp_rs1_val = resolve_val(dispatch.rs1_tag, dispatch.rs1_val);
    assign dp_rs2_val = resolve_val(dispatch.rs2_tag, dispatch.rs2_val);

    // operand wake-up from both broadcasts
    always_comb begin
        for (int i = 0; i < N; i++) begin
            rs1_wake[i]  = occupied[i] && !rs1_ok[i] &&
                           (tag_hit(rs1_tag[i], ex_cdb) || tag_hit(rs1_tag[i], load_cdb));
            rs2_wake[i]  = occupied[i] && !rs2_ok[i] &&
                           (tag_hit(rs2_tag[i], ex_cdb) || tag_hit(rs2_tag[i], load_cdb));
            rs1_wdata[i] = tag_hit(rs1_tag[i], ex_cdb) ? ex_cdb.data : load_cdb.data;
            rs2_wdata[i] = tag_hit(rs2_tag[i], ex_cdb) ? ex_cdb.data : load_cdb.data;
            eligible_st[i] = occupied[i] && !issued[i] && is_store[i] && committed[i] &&
                             rs1_ok[i] && rs2_ok[i];
            eligible_ld[i] = occupied[i] && !issued[i] && !is_store[i] && rs1_ok[i];
        end
    end

    // committed stores first, then lowest ready load
    always_comb begin
        pick_found = 1'b0;
        pick       = '0;
        for (int i = N - 1; i >= 1; i--) begin
            if (eligible_ld[i]) begin
                pick_found = 1'b1;
                pick       = TW'(i);
            end
        end
        for (int i = N - 1; i >= 1; i--) begin
            if (eligible_st[i]) begin
                pick_found = 1'b1;
                pick       = TW'(i);
            end
        end
    end

    assign issue_now = !req_valid && pick_found;
    assign req_fire  = req_valid && req_ready;
    assign full      = &occupied[N-1:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied  <= '0;
            issued    <= '0;
            committed <= '0;
            rs1_ok    <= '0;
            rs2_ok    <= '0;
            req_valid <= 1'b0;
        end else begin
            rs1_ok <= rs1_ok | rs1_wake;
            rs2_ok <= rs2_ok | rs2_wake;
            if (commit.valid) begin
                committed[commit.tag] <= 1'b1;
            end
            // load entry lives until its result is broadcast
            if (load_cdb.valid && !is_store[load_cdb.tag]) begin
                occupied[load_cdb.tag] <= 1'b0;
            end
            if (req_fire) begin
                req_valid <= 1'b0;
                if (is_store_op(req.op)) begin
                    occupied[req.tag] <= 1'b0;
                end
            end else if (issue_now) begin
                req_valid    <= 1'b1;
                issued[pick] <= 1'b1;
            end
            if (dispatch_valid) begin
                occupied[dispatch.tag]  <= 1'b1;
                issued[dispatch.tag]    <= 1'b0;
                committed[dispatch.tag] <= 1'b0;
                rs1_ok[dispatch.tag]    <= dp_rs1_ok;
                rs2_ok[dispatch.tag]    <= dp_rs2_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (rs1_wake[i]) begin
                rs1_val[i] <= rs1_wdata[i];
            end
            if (rs2_wake[i]) begin
                rs2_val[i] <= rs2_wdata[i];
            end
        end
        if (dispatch_valid) begin
            op_q[dispatch.tag]     <= dispatch.op;
            is_store[dispatch.tag] <= is_store_op(dispatch.op);
            imm_q[dispatch.tag]    <= dispatch.imm;
            rs1_tag[dispatch.tag]  <= dispatch.rs1_tag;
            rs2_tag[dispatch.tag]  <= dispatch.rs2_tag;
            rs1_val[dispatch.tag]  <= dp_rs1_val;
            rs2_val[dispatch.tag]  <= dp_rs2_val;
        end
        if (issue_now) begin
            req.tag  <= pick;
            req.op   <= op_q[pick];
            req.addr <= rs1_val[pick] + imm_q[pick];
            req.data <= rs2_val[pick];
        end
    end

    a_dispatch_free: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> (dispatch.tag != '0) && !occupied[dispatch.tag]);

    a_commit_store: assert property (@(posedge clk) disable iff (!rst_n)
        commit.valid |-> occupied[commit.tag] && is_store[commit.tag]);

endmodule

// ==== design/mem_access_unit.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module mem_access_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  lsu_pkg::mem_req_t    req,
    output logic                 req_ready,
    output lsu_pkg::wb_m2s_t     wb_m2s,
    input  lsu_pkg::wb_s2m_t     wb_s2m,
    output lsu_pkg::cdb_t        load_cdb,
    output lsu_pkg::store_done_t store_done
);
    import lsu_pkg::*;

    localparam int DW = `LSU_DATA_W;

    mau_state_e             state;
    mem_req_t               cur;
    logic [DW-1:0]          ld_data;
    logic [DW-1:0]          ld_fmt;
    logic [DW-1:0]          lane;
    logic [`LSU_SEL_W-1:0]  be;
    logic [1:0]             off;

    function automatic logic is_aligned(mem_req_t r);
        case (r.op)
            MEM_LH, MEM_LHU, MEM_SH: return r.addr[0] == 1'b0;
            MEM_LW, MEM_SW:          return r.addr[1:0] == 2'b00;
            default:                 return 1'b1;
        endcase
    endfunction

    assign off       = cur.addr[1:0];
    assign req_ready = (state == MAU_IDLE);

    always_comb begin
        case (cur.op)
            MEM_LB, MEM_LBU, MEM_SB: be = 'b0001;
            MEM_LH, MEM_LHU, MEM_SH: be = 'b0011;
            default:                 be = 'b1111;
        endcase
        wb_m2s.cyc = (state == MAU_BUS);
        wb_m2s.stb = (state == MAU_BUS);
        wb_m2s.we  = is_store_op(cur.op);
        wb_m2s.adr = cur.addr;
        wb_m2s.dat = cur.data << {off, 3'b000};
        wb_m2s.sel = be << off;
    end

    // pick out the addressed lane and extend
    always_comb begin
        lane = wb_s2m.dat >> {off, 3'b000};
        case (cur.op)
            MEM_LB:  ld_fmt = {{(DW - 8){lane[7]}}, lane[7:0]};
            MEM_LBU: ld_fmt = {{(DW - 8){1'b0}}, lane[7:0]};
            MEM_LH:  ld_fmt = {{(DW - 16){lane[15]}}, lane[15:0]};
            MEM_LHU: ld_fmt = {{(DW - 16){1'b0}}, lane[15:0]};
            default: ld_fmt = lane;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MAU_IDLE;
        end else begin
            case (state)
                MAU_IDLE: if (req_valid) state <= MAU_BUS;
                MAU_BUS:  if (wb_s2m.ack) state <= MAU_DONE;
                default:  state <= MAU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur <= req;
        end
        if (state == MAU_BUS && wb_s2m.ack) begin
            ld_data <= ld_fmt;
        end
    end

    assign load_cdb   = '{valid: (state == MAU_DONE) && !is_store_op(cur.op),
                          tag: cur.tag, data: ld_data};
    assign store_done = '{valid: (state == MAU_DONE) && is_store_op(cur.op), tag: cur.tag};

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |-> is_aligned(req));

endmodule

// ==== design/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  lsu_pkg::wb_m2s_t host_m2s,
    output lsu_pkg::wb_s2m_t host_s2m,
    input  lsu_pkg::wb_m2s_t lsu_m2s,
    output lsu_pkg::wb_s2m_t lsu_s2m,
    output lsu_pkg::wb_m2s_t mem_m2s,
    input  lsu_pkg::wb_s2m_t mem_s2m
);
    import lsu_pkg::*;

    arb_state_e state;

    // grant taken only from idle with the host first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (host_m2s.cyc) state <= ARB_GRANT_HOST;
                    else if (lsu_m2s.cyc) state <= ARB_GRANT_LSU;
                end
                ARB_GRANT_HOST: if (!host_m2s.cyc) state <= ARB_IDLE;
                ARB_GRANT_LSU:  if (!lsu_m2s.cyc) state <= ARB_IDLE;
                default:        state <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            ARB_GRANT_HOST: mem_m2s = host_m2s;
            ARB_GRANT_LSU:  mem_m2s = lsu_m2s;
            default:        mem_m2s = '0;
        endcase
    end

    assign host_s2m = '{ack: mem_s2m.ack && (state == ARB_GRANT_HOST), dat: mem_s2m.dat};
    assign lsu_s2m  = '{ack: mem_s2m.ack && (state == ARB_GRANT_LSU), dat: mem_s2m.dat};

    // at most one ack per access
    a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (host_s2m.ack || lsu_s2m.ack) |=> !(host_s2m.ack || lsu_s2m.ack));

    // an ack only reaches a master that still has its cycle open
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (host_s2m.ack |-> host_m2s.cyc) and (lsu_s2m.ack |-> lsu_m2s.cyc));

endmodule

// ==== design/data_mem.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module data_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  lsu_pkg::wb_m2s_t wb_m2s,
    output lsu_pkg::wb_s2m_t wb_s2m
);
    import lsu_pkg::*;

    localparam int AW = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
    logic [`LSU_DATA_W-1:0] rdata_q;
    logic [AW-1:0]          widx;
    logic                   ack_q;
    logic                   access;

    assign widx   = wb_m2s.adr[AW+1:2];
    // no access in the ack cycle, so back-to-back strobes get one ack each
    assign access = wb_m2s.cyc && wb_m2s.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_m2s.we) begin
                for (int b = 0; b < `LSU_SEL_W; b++) begin
                    if (wb_m2s.sel[b]) mem[widx][8*b +: 8] <= wb_m2s.dat[8*b +: 8];
                end
            end
            rdata_q <= mem[widx];
        end
    end

    assign wb_s2m = '{ack: ack_q, dat: rdata_q};

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dispatch_valid,
    input  lsu_pkg::dispatch_t   dispatch,
    input  lsu_pkg::cdb_t        ex_cdb,
    input  lsu_pkg::commit_t     commit,
    input  lsu_pkg::wb_m2s_t     host_m2s,
    output lsu_pkg::cdb_t        load_cdb,
    output lsu_pkg::store_done_t store_done,
    output logic                 full,
    output lsu_pkg::wb_s2m_t     host_s2m
);
    import lsu_pkg::*;

    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    wb_m2s_t  lsu_m2s;
    wb_s2m_t  lsu_s2m;
    wb_m2s_t  mem_m2s;
    wb_s2m_t  mem_s2m;

    // buffer also snoops its own load results
    load_store_buffer u_lsb (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .ex_cdb         (ex_cdb),
        .load_cdb       (load_cdb),
        .commit         (commit),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .full           (full)
    );

    mem_access_unit u_mau (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .wb_m2s     (lsu_m2s),
        .wb_s2m     (lsu_s2m),
        .load_cdb   (load_cdb),
        .store_done (store_done)
    );

    wb_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_m2s (host_m2s),
        .host_s2m (host_s2m),
        .lsu_m2s  (lsu_m2s),
        .lsu_s2m  (lsu_s2m),
        .mem_m2s  (mem_m2s),
        .mem_s2m  (mem_s2m)
    );

    data_mem u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_m2s (mem_m2s),
        .wb_s2m (mem_s2m)
    );

endmodule

// ==== sim/tb_lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int            DW            = `LSU_DATA_W;
    localparam int            TW            = `LSU_TAG_W;
    localparam int            N             = `LSU_ENTRIES;
    localparam logic [DW-1:0] BASE          = 32'h0000_0040;
    localparam int            HOST_WINDOW   = 50;
    localparam int            RESULT_WINDOW = 200;

    typedef enum logic [3:0] {
        K_HOST_WR,
        K_HOST_RD,
        K_DISPATCH,
        K_EX_CDB,
        K_COMMIT,
        K_WAIT_LOAD,
        K_WAIT_STORE,
        K_FULL,
        K_SILENT,
        K_IDLE
    } kind_e;

    typedef struct packed {
        kind_e         kind;
        dispatch_t     dp;
        logic [DW-1:0] addr;
        logic [DW-1:0] data;
        logic [TW-1:0] tag;
        logic [DW-1:0] exp;
        logic [3:0]    gap;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    cdb_t        ex_cdb;
    commit_t     commit;
    wb_m2s_t     host_m2s;
    cdb_t        load_cdb;
    store_done_t store_done;
    logic        full;
    wb_s2m_t     host_s2m;

    step_t         steps[$];
    logic [DW-1:0] ref_mem [`LSU_MEM_WORDS];
    cdb_t          ld_seen [N];
    store_done_t   st_seen [N];
    int            ld_cnt [N];
    int            st_cnt [N];
    int            cycles;
    int            cycle_limit;

    lsu_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .ex_cdb         (ex_cdb),
        .commit         (commit),
        .host_m2s       (host_m2s),
        .load_cdb       (load_cdb),
        .store_done     (store_done),
        .full           (full),
        .host_s2m       (host_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            report_failure();
        end
    end

    // result pulses last one cycle, record them per tag
    always @(negedge clk) begin
        if (rst_n && load_cdb.valid) begin
            ld_seen[load_cdb.tag] = load_cdb;
            ld_cnt[load_cdb.tag]  = ld_cnt[load_cdb.tag] + 1;
        end
        if (rst_n && store_done.valid) begin
            st_seen[store_done.tag] = store_done;
            st_cnt[store_done.tag]  = st_cnt[store_done.tag] + 1;
        end
    end

    task automatic report_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_cdb(input cdb_t got, input cdb_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %0b/%0d/%h, expected %0b/%0d/%h (valid/tag/data)",
                     $time, what, got.valid, got.tag, got.data, exp.valid, exp.tag, exp.data);
            report_failure();
        end
    endtask

    task automatic check_store_done(input store_done_t got, input store_done_t exp,
                                    input string what);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %0b/%0d, expected %0b/%0d (valid/tag)",
                     $time, what, got.valid, got.tag, exp.valid, exp.tag);
            report_failure();
        end
    endtask

    task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %0b, expected %0b", $time, what, got, exp);
            report_failure();
        end
    endtask

    // reference memory, byte lanes per access size
    function automatic int word_of(logic [DW-1:0] addr);
        return (addr >> 2) % `LSU_MEM_WORDS;
    endfunction

    function automatic int access_bytes(mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            default:                 return 4;
        endcase
    endfunction

    function automatic void ref_store(mem_op_e op, logic [DW-1:0] addr, logic [DW-1:0] val);
        logic [`LSU_SEL_W-1:0] sel;
        logic [DW-1:0]         lanes;
        case (access_bytes(op))
            1: begin
                sel   = 4'b0001 << addr[1:0];
                lanes = {4{val[7:0]}};
            end
            2: begin
                sel   = 4'b0011 << addr[1:0];
                lanes = {2{val[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                lanes = val;
            end
        endcase
        for (int b = 0; b < `LSU_SEL_W; b++) begin
            if (sel[b]) ref_mem[word_of(addr)][8*b +: 8] = lanes[8*b +: 8];
        end
    endfunction

    function automatic logic [DW-1:0] ref_load(mem_op_e op, logic [DW-1:0] addr);
        logic [DW-1:0] w;
        logic [7:0]    b;
        logic [15:0]   h;
        w = ref_mem[word_of(addr)];
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic step_t new_step(kind_e kind);
        step_t s;
        s      = '0;
        s.kind = kind;
        return s;
    endfunction

    task automatic host_write_at(logic [DW-1:0] addr, logic [DW-1:0] data);
        step_t s;
        s      = new_step(K_HOST_WR);
        s.addr = addr;
        s.data = data;
        s.gap  = $urandom % 3;
        ref_store(MEM_SW, addr, data);
        steps.push_back(s);
    endtask

    task automatic host_read_at(logic [DW-1:0] addr);
        step_t s;
        s      = new_step(K_HOST_RD);
        s.addr = addr;
        s.exp  = ref_mem[word_of(addr)];
        s.gap  = $urandom % 3;
        steps.push_back(s);
    endtask

    task automatic dispatch_op(mem_op_e op, logic [TW-1:0] tag, logic [TW-1:0] rs1_tag,
                               logic [DW-1:0] rs1_val, logic [DW-1:0] imm,
                               logic [TW-1:0] rs2_tag, logic [DW-1:0] rs2_val);
        step_t s;
        s            = new_step(K_DISPATCH);
        s.dp.op      = op;
        s.dp.tag     = tag;
        s.dp.imm     = imm;
        s.dp.rs1_tag = rs1_tag;
        s.dp.rs1_val = rs1_val;
        s.dp.rs2_tag = rs2_tag;
        s.dp.rs2_val = rs2_val;
        steps.push_back(s);
    endtask

    task automatic broadcast_ex(logic [TW-1:0] tag, logic [DW-1:0] data);
        step_t s;
        s      = new_step(K_EX_CDB);
        s.tag  = tag;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic commit_store(logic [TW-1:0] tag);
        step_t s;
        s     = new_step(K_COMMIT);
        s.tag = tag;
        steps.push_back(s);
    endtask

    task automatic expect_load(logic [TW-1:0] tag, mem_op_e op, logic [DW-1:0] addr);
        step_t s;
        s     = new_step(K_WAIT_LOAD);
        s.tag = tag;
        s.exp = ref_load(op, addr);
        steps.push_back(s);
    endtask

    task automatic expect_store(logic [TW-1:0] tag, mem_op_e op, logic [DW-1:0] addr,
                                logic [DW-1:0] val);
        step_t s;
        s     = new_step(K_WAIT_STORE);
        s.tag = tag;
        ref_store(op, addr, val);
        steps.push_back(s);
    endtask

    task automatic expect_full(logic f);
        step_t s;
        s     = new_step(K_FULL);
        s.exp = DW'(f);
        steps.push_back(s);
    endtask

    task automatic expect_silent(logic [TW-1:0] tag);
        step_t s;
        s     = new_step(K_SILENT);
        s.tag = tag;
        steps.push_back(s);
    endtask

    task automatic idle_for(int n);
        step_t s;
        s     = new_step(K_IDLE);
        s.gap = n;
        steps.push_back(s);
    endtask

    // old word before commit, merged lanes after
    task automatic store_case(mem_op_e op, logic [TW-1:0] tag, logic [DW-1:0] addr,
                              logic [DW-1:0] val);
        logic [DW-1:0] word_addr;
        word_addr = {addr[DW-1:2], 2'b00};
        dispatch_op(op, tag, '0, word_addr, DW'(addr[1:0]), '0, val);
        idle_for(6);
        expect_silent(tag);
        host_read_at(word_addr);
        commit_store(tag);
        expect_store(tag, op, addr, val);
        host_read_at(word_addr);
    endtask

    task automatic build_table();
        mem_op_e       ops [5];
        mem_op_e       pend_op [N];
        logic [DW-1:0] pend_addr [N];
        logic [DW-1:0] ld_val;
        int            t;
        ops = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        for (int i = 0; i < 16; i++) begin
            host_write_at(BASE + 4 * i, $urandom);
        end
        for (int i = 0; i < 16; i++) begin
            host_read_at(BASE + 4 * i);
        end
        // bytes and halves of both signs
        host_write_at(BASE, 32'h8F7E_01F2);
        t = 0;
        for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 5; k++) begin
                if (off % access_bytes(ops[k]) == 0) begin
                    t++;
                    pend_op[t]   = ops[k];
                    pend_addr[t] = BASE + off;
                    dispatch_op(ops[k], TW'(t), '0, BASE, off, '0, '0);
                end
            end
        end
        for (int i = 1; i <= t; i++) begin
            expect_load(TW'(i), pend_op[i], pend_addr[i]);
        end
        store_case(MEM_SB, 1, BASE + 5, 32'h0000_00A5);
        store_case(MEM_SH, 2, BASE + 10, 32'h1234_C3D2);
        // base from an ex tag, then store data from a load tag
        dispatch_op(MEM_LW, 3, 9, '0, 4, '0, '0);
        idle_for(6);
        expect_silent(3);
        broadcast_ex(9, BASE + 8);
        expect_load(3, MEM_LW, BASE + 12);
        dispatch_op(MEM_LH, 4, '0, BASE, 2, '0, '0);
        dispatch_op(MEM_SW, 5, '0, BASE + 16, '0, 4, '0);
        ld_val = ref_load(MEM_LH, BASE + 2);
        expect_load(4, MEM_LH, BASE + 2);
        commit_store(5);
        expect_store(5, MEM_SW, BASE + 16, ld_val);
        host_read_at(BASE + 16);
        // every usable entry waits on one ex tag
        for (int i = 1; i < N; i++) begin
            dispatch_op(MEM_LW, TW'(i), 12, '0, 4 * (i - 1), '0, '0);
        end
        expect_full(1'b1);
        broadcast_ex(12, BASE);
        for (int i = 1; i < N; i++) begin
            expect_load(TW'(i), MEM_LW, BASE + 4 * (i - 1));
        end
        expect_full(1'b0);
        // host reads race with load traffic
        for (int i = 1; i <= 6; i++) begin
            dispatch_op(ops[i % 5], TW'(i), '0, BASE + 4 * i, '0, '0, '0);
            host_read_at(BASE + 4 * (i + 8));
        end
        for (int i = 1; i <= 6; i++) begin
            expect_load(TW'(i), ops[i % 5], BASE + 4 * i);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic host_cycle(input logic we, input logic [DW-1:0] addr,
                              input logic [DW-1:0] data, output logic [DW-1:0] rdata);
        int waited;
        waited   = 0;
        host_m2s = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: data, sel: '1};
        do begin
            @(negedge clk);
            waited++;
            if (waited > HOST_WINDOW) begin
                $display("host access to %h got no ack within %0d cycles", addr, HOST_WINDOW);
                report_failure();
            end
        end while (!host_s2m.ack);
        rdata = host_s2m.dat;
        next_cycle();
        host_m2s = '0;
        // arbiter has to see cyc low before the next grant
        next_cycle();
    endtask

    task automatic wait_load(input logic [TW-1:0] tag, input logic [DW-1:0] exp);
        cdb_t want;
        int   waited;
        waited     = 0;
        want.valid = 1'b1;
        want.tag   = tag;
        want.data  = exp;
        while (ld_cnt[tag] == 0) begin
            if (waited == RESULT_WINDOW) begin
                $display("no load result for tag %0d within %0d cycles", tag, RESULT_WINDOW);
                report_failure();
            end
            next_cycle();
            waited++;
        end
        check_cdb(ld_seen[tag], want, $sformatf("load result tag %0d", tag));
        if (ld_cnt[tag] != 1) begin
            $display("load tag %0d returned %0d times instead of once", tag, ld_cnt[tag]);
            report_failure();
        end
        ld_cnt[tag] = 0;
    endtask

    task automatic wait_store(input logic [TW-1:0] tag);
        store_done_t want;
        int          waited;
        waited     = 0;
        want.valid = 1'b1;
        want.tag   = tag;
        while (st_cnt[tag] == 0) begin
            if (waited == RESULT_WINDOW) begin
                $display("no store completion for tag %0d within %0d cycles", tag, RESULT_WINDOW);
                report_failure();
            end
            next_cycle();
            waited++;
        end
        check_store_done(st_seen[tag], want, $sformatf("store done tag %0d", tag));
        if (st_cnt[tag] != 1) begin
            $display("store tag %0d completed %0d times instead of once", tag, st_cnt[tag]);
            report_failure();
        end
        st_cnt[tag] = 0;
    endtask

    task automatic run_step(input step_t s);
        logic [DW-1:0] rdata;
        repeat (s.gap) next_cycle();
        case (s.kind)
            K_HOST_WR: host_cycle(1'b1, s.addr, s.data, rdata);
            K_HOST_RD: begin
                host_cycle(1'b0, s.addr, '0, rdata);
                check_word(rdata, s.exp, $sformatf("host read of %h", s.addr));
            end
            K_DISPATCH: begin
                dispatch       = s.dp;
                dispatch_valid = 1'b1;
                next_cycle();
                dispatch_valid = 1'b0;
            end
            K_EX_CDB: begin
                ex_cdb = '{valid: 1'b1, tag: s.tag, data: s.data};
                next_cycle();
                ex_cdb = '0;
            end
            K_COMMIT: begin
                commit = '{valid: 1'b1, tag: s.tag};
                next_cycle();
                commit = '0;
            end
            K_WAIT_LOAD:  wait_load(s.tag, s.exp);
            K_WAIT_STORE: wait_store(s.tag);
            K_FULL:       check_flag(full, s.exp[0], "full flag");
            K_SILENT: begin
                if (ld_cnt[s.tag] != 0 || st_cnt[s.tag] != 0) begin
                    $display("tag %0d finished before its operand or commit arrived", s.tag);
                    report_failure();
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        int extra;
        void'($urandom(91021));
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        ex_cdb         = '0;
        commit         = '0;
        host_m2s       = '0;
        cycles         = 0;
        for (int i = 0; i < N; i++) begin
            ld_cnt[i] = 0;
            st_cnt[i] = 0;
        end
        build_table();
        cycle_limit = 20 * steps.size() + 100;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag(full, 1'b0, "full after reset");
        check_flag(load_cdb.valid, 1'b0, "load_cdb valid after reset");
        check_flag(store_done.valid, 1'b0, "store_done valid after reset");
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        extra = 0;
        for (int i = 0; i < N; i++) begin
            extra += ld_cnt[i] + st_cnt[i];
        end
        if (extra == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d results arrived that no step was waiting for", extra);
            report_failure();
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
design/lsu_pkg.sv
design/load_store_buffer.sv
design/mem_access_unit.sv
design/wb_arbiter.sv
design/data_mem.sv
design/lsu_top.sv
sim/tb_lsu_top.sv
